/* source/riscv_isa_pkg.sv */
// RV32I instruction encodings

package riscv_isa_pkg;

    // ----------------------------------------------------------------------
    // major opcodes
    // ----------------------------------------------------------------------
    // only the control-flow opcodes the frontend scans for get a name
    typedef enum logic [6:0] {
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    // ----------------------------------------------------------------------
    // instruction formats
    // ----------------------------------------------------------------------
    // conditional branch, imm[12|10:5] rs2 rs1 funct3 imm[4:1|11] opcode
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_type_t;

    // jal, imm[20|10:1|11|19:12] rd opcode
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_type_t;

    // one fetched word seen as branch, as jump or as raw bits
    typedef union packed {
        b_type_t     b;
        j_type_t     j;
        logic [31:0] raw;
    } instr_u;

endpackage

/* source/frontend_pkg.sv */
// Fetch frontend definitions

package frontend_pkg;

    // ----------------------------------------------------------------------
    // addressing
    // ----------------------------------------------------------------------
    localparam int XLEN_ADDR   = 32;
    // sequential step of one uncompressed instruction
    localparam int INSTR_BYTES = 4;

    typedef logic [XLEN_ADDR-1:0] addr_t;

    // control-flow kind attached to every fetch entry
    typedef enum logic [1:0] {
        NO_CF  = 2'd0,
        BRANCH = 2'd1,
        JUMP   = 2'd2
    } cf_e;

    // ----------------------------------------------------------------------
    // table and queue sizes
    // ----------------------------------------------------------------------
    localparam int BHT_ENTRIES = 16;
    localparam int BHT_IDX_W   = 4;
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W = 2;

    // entry handed to the back-end as 98 bits
    typedef struct packed {
        addr_t       pc;
        logic [31:0] instr;
        cf_e         cf;
        addr_t       target;
    } fetch_entry_t;

endpackage

/* source/bp_resolve_if.sv */
// Resolved branch bus
`timescale 1ns/1ps

interface bp_resolve_if import frontend_pkg::*; ();
    // single-cycle event from the back-end without a handshake
    logic  valid;
    addr_t pc;
    logic  is_branch;
    logic  taken;
    logic  mispredict;
    addr_t target;

    // history table training
    modport bht_mp (input valid, input is_branch, input pc, input taken);
    // fetch redirect on misprediction
    modport ctrl_mp (input valid, input mispredict, input target);
endinterface

/* source/predict_if.sv */
// Scanned fetch response bus
`timescale 1ns/1ps

interface predict_if import frontend_pkg::*; ();
    logic        valid;
    addr_t       pc;
    logic [31:0] instr;
    cf_e         cf;
    logic        taken;
    addr_t       target;

    modport src_mp (output valid, output pc, output instr, output cf, output taken,
                    output target);
    modport ctrl_mp (input taken, input target);
    modport queue_mp (input valid, input pc, input instr, input cf, input target);
endinterface

/* source/fetch_ctrl.sv */
// Next-PC and memory request control
`timescale 1ns/1ps

module fetch_ctrl import frontend_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  addr_t                boot_addr_i,
    input  logic                 ex_valid_i,
    input  addr_t                trap_vector_i,
    input  logic                 eret_i,
    input  addr_t                epc_i,
    input  logic                 queue_room_i,
    input  logic                 imem_ready_i,
    input  logic                 imem_rvalid_i,
    bp_resolve_if.ctrl_mp        res,
    predict_if.ctrl_mp           pred,
    output logic                 imem_req_o,
    output addr_t                imem_addr_o,
    output logic                 rsp_valid_o,
    output addr_t                rsp_pc_o,
    output logic                 flush_o
);
    // set during reset, loads the boot address once
    logic  rst_load_q;
    addr_t npc_q;
    addr_t npc_d;
    addr_t fetch_addr;
    // address of the request whose response is due
    addr_t rsp_pc_q;
    logic  is_mispredict;
    logic  accepted;

    assign is_mispredict = res.valid & res.mispredict;
    // any back-end redirect empties the queue
    assign flush_o       = ex_valid_i | eret_i | is_mispredict;

    // ----------------------------------------------------------------------
    // fetch address, highest priority first in the chain below
    // ----------------------------------------------------------------------
    always_comb begin
        if (ex_valid_i) begin
            fetch_addr = trap_vector_i;
        end else if (eret_i) begin
            fetch_addr = epc_i;
        end else if (is_mispredict) begin
            fetch_addr = res.target;
        end else if (pred.taken) begin
            // target goes out in the response cycle itself
            fetch_addr = pred.target;
        end else begin
            fetch_addr = npc_q;
        end
    end

    // no request until the boot address sits in npc_q
    assign imem_req_o  = ~rst_load_q & queue_room_i;
    assign imem_addr_o = fetch_addr;
    assign accepted    = imem_req_o & imem_ready_i;

    // a redirect that is not accepted stays pending in npc_q
    always_comb begin
        if (rst_load_q) begin
            npc_d = boot_addr_i;
        end else if (accepted) begin
            npc_d = fetch_addr + addr_t'(INSTR_BYTES);
        end else begin
            npc_d = fetch_addr;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rst_load_q <= 1'b1;
            npc_q      <= '0;
        end else begin
            rst_load_q <= 1'b0;
            npc_q      <= npc_d;
        end
    end

    // capture the address of each accepted request
    always_ff @(posedge clk_i) begin
        if (accepted) begin
            rsp_pc_q <= fetch_addr;
        end
    end

    // responses landing in a redirect cycle belong to the old path
    assign rsp_valid_o = imem_rvalid_i & ~flush_o;
    assign rsp_pc_o    = rsp_pc_q;

endmodule

/* source/branch_predict.sv */
// Instruction scan and prediction
`timescale 1ns/1ps

module branch_predict
    import frontend_pkg::*;
    import riscv_isa_pkg::*;
(
    input  logic                 rsp_valid_i,
    input  addr_t                rsp_pc_i,
    input  instr_u               rsp_instr_i,
    input  logic                 bht_valid_i,
    input  logic                 bht_taken_i,
    output logic [BHT_IDX_W-1:0] bht_idx_o,
    predict_if.src_mp            pred
);
    // sign-extended immediates of both views of the word
    addr_t b_imm;
    addr_t j_imm;
    logic  is_branch;
    logic  is_jal;
    logic  taken;
    cf_e   cf;
    addr_t target;

    assign b_imm = {{19{rsp_instr_i.b.imm12}}, rsp_instr_i.b.imm12, rsp_instr_i.b.imm11,
                    rsp_instr_i.b.imm10_5, rsp_instr_i.b.imm4_1, 1'b0};
    assign j_imm = {{11{rsp_instr_i.j.imm20}}, rsp_instr_i.j.imm20, rsp_instr_i.j.imm19_12,
                    rsp_instr_i.j.imm11, rsp_instr_i.j.imm10_1, 1'b0};

    // funct3 010 and 011 are not branch encodings
    assign is_branch = (rsp_instr_i.b.opcode == OPC_BRANCH) && (rsp_instr_i.b.funct3[2:1] != 2'b01);
    assign is_jal    = (rsp_instr_i.j.opcode == OPC_JAL);

    // table index from word address bits
    assign bht_idx_o = rsp_pc_i[BHT_IDX_W+1:2];

    // ----------------------------------------------------------------------
    // taken decision
    // ----------------------------------------------------------------------
    always_comb begin
        taken  = 1'b0;
        cf     = NO_CF;
        target = '0;
        if (rsp_valid_i && is_jal) begin
            taken  = 1'b1;
            cf     = JUMP;
            target = rsp_pc_i + j_imm;
        end else if (rsp_valid_i && is_branch) begin
            // dynamic when trained, else backward taken
            taken = bht_valid_i ? bht_taken_i : b_imm[XLEN_ADDR-1];
            if (taken) begin
                cf     = BRANCH;
                target = rsp_pc_i + b_imm;
            end
        end
    end

    assign pred.valid  = rsp_valid_i;
    assign pred.pc     = rsp_pc_i;
    assign pred.instr  = rsp_instr_i.raw;
    assign pred.cf     = cf;
    assign pred.taken  = taken;
    assign pred.target = target;

endmodule

/* source/bht.sv */
// Branch history table
`timescale 1ns/1ps

module bht import frontend_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic [BHT_IDX_W-1:0] lookup_idx_i,
    bp_resolve_if.bht_mp         res,
    output logic                 valid_o,
    output logic                 taken_o
);
    logic [BHT_ENTRIES-1:0] valid_q;
    // 2-bit saturating counters, msb is the prediction
    logic [1:0]             cnt_q [BHT_ENTRIES];
    logic [BHT_IDX_W-1:0]   upd_idx;
    logic                   upd;

    assign upd_idx = res.pc[BHT_IDX_W+1:2];
    // only conditional branches train the table
    assign upd     = res.valid & res.is_branch;

    // combinational lookup
    assign valid_o = valid_q[lookup_idx_i];
    assign taken_o = cnt_q[lookup_idx_i][1];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (upd) begin
            valid_q[upd_idx] <= 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // counter update
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (upd) begin
            if (!valid_q[upd_idx]) begin
                // first outcome seeds a weak state
                cnt_q[upd_idx] <= res.taken ? 2'b10 : 2'b01;
            end else if (res.taken && cnt_q[upd_idx] != 2'b11) begin
                cnt_q[upd_idx] <= cnt_q[upd_idx] + 2'b01;
            end else if (!res.taken && cnt_q[upd_idx] != 2'b00) begin
                cnt_q[upd_idx] <= cnt_q[upd_idx] - 2'b01;
            end
        end
    end

endmodule

/* source/instr_queue.sv */
// Fetch entry queue
`timescale 1ns/1ps

module instr_queue import frontend_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        flush_i,
    predict_if.queue_mp pred,
    input  logic        fetch_ready_i,
    output logic        room_o,
    output logic        fetch_valid_o,
    output addr_t       fetch_pc_o,
    output logic [31:0] fetch_instr_o,
    output cf_e         fetch_cf_o,
    output addr_t       fetch_target_o
);
    fetch_entry_t             mem_q [QUEUE_DEPTH];
    fetch_entry_t             head;
    logic [QUEUE_PTR_W-1:0]   rd_ptr_q;
    logic [QUEUE_PTR_W-1:0]   wr_ptr_q;
    logic [QUEUE_PTR_W:0]     count_q;
    logic                     push;
    logic                     pop;

    assign push = pred.valid & ~flush_i;
    assign pop  = fetch_valid_o & fetch_ready_i & ~flush_i;

    // two free slots cover a response already on its way
    assign room_o = (count_q <= (QUEUE_PTR_W+1)'(QUEUE_DEPTH - 2));

    // ----------------------------------------------------------------------
    // pointers and fill level
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            // depth is a power of two, pointers wrap on their own
            if (push) wr_ptr_q <= wr_ptr_q + QUEUE_PTR_W'(1);
            if (pop) rd_ptr_q <= rd_ptr_q + QUEUE_PTR_W'(1);
            if (push && !pop) begin
                count_q <= count_q + (QUEUE_PTR_W+1)'(1);
            end else if (pop && !push) begin
                count_q <= count_q - (QUEUE_PTR_W+1)'(1);
            end
        end
    end

    // storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= '{pc: pred.pc, instr: pred.instr, cf: pred.cf,
                                 target: pred.target};
        end
    end

    // head of queue towards the back-end
    assign head           = mem_q[rd_ptr_q];
    assign fetch_valid_o  = (count_q != '0);
    assign fetch_pc_o     = head.pc;
    assign fetch_instr_o  = head.instr;
    assign fetch_cf_o     = head.cf;
    assign fetch_target_o = head.target;

endmodule

/* source/frontend_top.sv */
// Instruction fetch frontend
`timescale 1ns/1ps

module frontend_top
    import frontend_pkg::*;
    import riscv_isa_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_ni,
    input  addr_t       boot_addr_i,
    // instruction memory
    output logic        imem_req_o,
    output addr_t       imem_addr_o,
    input  logic        imem_ready_i,
    input  logic        imem_rvalid_i,
    input  logic [31:0] imem_rdata_i,
    // back-end
    output logic        fetch_valid_o,
    input  logic        fetch_ready_i,
    output addr_t       fetch_pc_o,
    output logic [31:0] fetch_instr_o,
    output cf_e         fetch_cf_o,
    output addr_t       fetch_target_o,
    // redirects
    input  logic        ex_valid_i,
    input  addr_t       trap_vector_i,
    input  logic        eret_i,
    input  addr_t       epc_i,
    input  logic        res_valid_i,
    input  addr_t       res_pc_i,
    input  logic        res_is_branch_i,
    input  logic        res_taken_i,
    input  logic        res_mispredict_i,
    input  addr_t       res_target_i
);
    logic                 queue_room;
    logic                 rsp_valid;
    addr_t                rsp_pc;
    logic                 flush;
    logic [BHT_IDX_W-1:0] bht_idx;
    logic                 bht_valid;
    logic                 bht_taken;
    // response word, decoded as branch or jump downstream
    instr_u               rsp_instr;

    bp_resolve_if res_bus ();
    predict_if    pred_bus ();

    // ----------------------------------------------------------------------
    // resolved branch from the back-end
    // ----------------------------------------------------------------------
    assign res_bus.valid      = res_valid_i;
    assign res_bus.pc         = res_pc_i;
    assign res_bus.is_branch  = res_is_branch_i;
    assign res_bus.taken      = res_taken_i;
    assign res_bus.mispredict = res_mispredict_i;
    assign res_bus.target     = res_target_i;

    assign rsp_instr = imem_rdata_i;

    fetch_ctrl i_fetch_ctrl (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .boot_addr_i   (boot_addr_i),
        .ex_valid_i    (ex_valid_i),
        .trap_vector_i (trap_vector_i),
        .eret_i        (eret_i),
        .epc_i         (epc_i),
        .queue_room_i  (queue_room),
        .imem_ready_i  (imem_ready_i),
        .imem_rvalid_i (imem_rvalid_i),
        .res           (res_bus),
        .pred          (pred_bus),
        .imem_req_o    (imem_req_o),
        .imem_addr_o   (imem_addr_o),
        .rsp_valid_o   (rsp_valid),
        .rsp_pc_o      (rsp_pc),
        .flush_o       (flush)
    );

    branch_predict i_branch_predict (
        .rsp_valid_i (rsp_valid),
        .rsp_pc_i    (rsp_pc),
        .rsp_instr_i (rsp_instr),
        .bht_valid_i (bht_valid),
        .bht_taken_i (bht_taken),
        .bht_idx_o   (bht_idx),
        .pred        (pred_bus)
    );

    bht i_bht (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .lookup_idx_i (bht_idx),
        .res          (res_bus),
        .valid_o      (bht_valid),
        .taken_o      (bht_taken)
    );

    instr_queue i_instr_queue (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .flush_i        (flush),
        .pred           (pred_bus),
        .fetch_ready_i  (fetch_ready_i),
        .room_o         (queue_room),
        .fetch_valid_o  (fetch_valid_o),
        .fetch_pc_o     (fetch_pc_o),
        .fetch_instr_o  (fetch_instr_o),
        .fetch_cf_o     (fetch_cf_o),
        .fetch_target_o (fetch_target_o)
    );

endmodule

/* verification/imem_model.sv */
// Instruction memory model
`timescale 1ns/1ps

module imem_model import frontend_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        req_i,
    input  addr_t       addr_i,
    output logic        ready_o,
    output logic        rvalid_o,
    output logic [31:0] rdata_o
);
    // 64 words, loaded by the testbench before reset releases
    logic [31:0] mem [64];

    // ready drops on about one cycle in four and changes on falling edges
    initial begin
        void'($urandom(50));
        ready_o = 1'b1;
        forever begin
            @(negedge clk_i);
            ready_o = ($urandom % 4) != 0;
        end
    end

    // one response exactly one cycle after acceptance
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rvalid_o <= 1'b0;
            rdata_o  <= '0;
        end else begin
            rvalid_o <= req_i & ready_o;
            if (req_i && ready_o) begin
                rdata_o <= mem[addr_i[7:2]];
            end
        end
    end

endmodule

/* verification/frontend_tb.sv */
// Fetch frontend testbench
`timescale 1ns/1ps

module frontend_tb
    import frontend_pkg::*;
    import riscv_isa_pkg::*;
();
    localparam addr_t BOOT_ADDR = 32'h0000_00C0;
    localparam addr_t TRAP_VEC  = 32'h0000_0080;
    localparam addr_t EPC       = 32'h0000_0040;

    // what one table row does
    typedef enum logic [2:0] {
        ACT_EXPECT, ACT_EXCEPT, ACT_ERET, ACT_EX_ERET,
        ACT_TAKEN, ACT_NOT_TAKEN, ACT_MISPRED, ACT_STALL
    } act_e;

    typedef struct packed {
        act_e         act;
        addr_t        value;
        fetch_entry_t exp;
    } row_t;

    logic        clk_i;
    logic        rst_ni;
    addr_t       boot_addr_i;
    logic        imem_req_o;
    addr_t       imem_addr_o;
    logic        imem_ready_i;
    logic        imem_rvalid_i;
    logic [31:0] imem_rdata_i;
    logic        fetch_valid_o;
    logic        fetch_ready_i;
    addr_t       fetch_pc_o;
    logic [31:0] fetch_instr_o;
    cf_e         fetch_cf_o;
    addr_t       fetch_target_o;
    logic        ex_valid_i;
    addr_t       trap_vector_i;
    logic        eret_i;
    addr_t       epc_i;
    logic        res_valid_i;
    addr_t       res_pc_i;
    logic        res_is_branch_i;
    logic        res_taken_i;
    logic        res_mispredict_i;
    addr_t       res_target_i;

    logic [31:0] prog [64];
    row_t        rows [$];
    logic        table_ready = 1'b0;
    int          errors = 0;

    frontend_top UUT (.*);

    imem_model u_imem (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .req_i    (imem_req_o),
        .addr_i   (imem_addr_o),
        .ready_o  (imem_ready_i),
        .rvalid_o (imem_rvalid_i),
        .rdata_o  (imem_rdata_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // ----------------------------------------------------------------------
    // program and stimulus table
    // ----------------------------------------------------------------------
    // bne x2, x1 with a 13-bit byte offset
    function automatic logic [31:0] encode_branch(input logic [12:0] imm);
        instr_u w;
        w.b = '{imm12: imm[12], imm10_5: imm[10:5], rs2: 5'd1, rs1: 5'd2, funct3: 3'b001,
                imm4_1: imm[4:1], imm11: imm[11], opcode: OPC_BRANCH};
        return w.raw;
    endfunction

    // jal x0 with a 21-bit byte offset
    function automatic logic [31:0] encode_jal(input logic [20:0] imm);
        instr_u w;
        w.j = '{imm20: imm[20], imm10_1: imm[10:1], imm11: imm[11], imm19_12: imm[19:12],
                rd: 5'd0, opcode: OPC_JAL};
        return w.raw;
    endfunction

    task automatic build_program();
        // filler is addi with fields taken from the word index
        for (int i = 0; i < 64; i++) begin
            prog[i] = {i[24:0], 7'b0010011};
        end
        // 0xc8 jumps back to 0x20
        prog[6'h32] = encode_jal(-21'sd168);
        // forward branch 0x24 -> 0x34, backward branch 0x2c -> 0x20
        prog[6'h09] = encode_branch(13'sd16);
        prog[6'h0B] = encode_branch(-13'sd12);
        for (int i = 0; i < 64; i++) begin
            u_imem.mem[i] = prog[i];
        end
    endtask

    task automatic add_expect(input addr_t pc, input cf_e cf, input addr_t target);
        row_t r;
        r.act   = ACT_EXPECT;
        r.value = '0;
        r.exp   = '{pc: pc, instr: prog[pc[7:2]], cf: cf, target: target};
        rows.push_back(r);
    endtask

    task automatic add_event(input act_e act, input addr_t value);
        row_t r;
        r.act   = act;
        r.value = value;
        r.exp   = '0;
        rows.push_back(r);
    endtask

    task automatic build_table();
        // boot, jump, static prediction
        add_expect(32'hC0, NO_CF, 32'h0);
        add_expect(32'hC4, NO_CF, 32'h0);
        add_expect(32'hC8, JUMP, 32'h20);
        add_expect(32'h20, NO_CF, 32'h0);
        add_expect(32'h24, NO_CF, 32'h0);
        add_expect(32'h28, NO_CF, 32'h0);
        add_expect(32'h2C, BRANCH, 32'h20);
        add_expect(32'h20, NO_CF, 32'h0);
        // train the forward branch taken, then refetch it
        add_event(ACT_TAKEN, 32'h24);
        add_event(ACT_TAKEN, 32'h24);
        add_event(ACT_MISPRED, 32'h20);
        add_expect(32'h20, NO_CF, 32'h0);
        add_expect(32'h24, BRANCH, 32'h34);
        add_expect(32'h34, NO_CF, 32'h0);
        add_expect(32'h38, NO_CF, 32'h0);
        // counter drops back below the taken threshold
        add_event(ACT_NOT_TAKEN, 32'h24);
        add_event(ACT_NOT_TAKEN, 32'h24);
        add_event(ACT_MISPRED, 32'h20);
        add_expect(32'h20, NO_CF, 32'h0);
        add_expect(32'h24, NO_CF, 32'h0);
        add_expect(32'h28, NO_CF, 32'h0);
        // back-end redirects
        add_event(ACT_EXCEPT, 32'h0);
        add_expect(32'h80, NO_CF, 32'h0);
        add_expect(32'h84, NO_CF, 32'h0);
        add_event(ACT_ERET, 32'h0);
        add_expect(32'h40, NO_CF, 32'h0);
        add_expect(32'h44, NO_CF, 32'h0);
        add_event(ACT_MISPRED, 32'h60);
        add_expect(32'h60, NO_CF, 32'h0);
        add_event(ACT_EX_ERET, 32'h0);
        add_expect(32'h80, NO_CF, 32'h0);
        add_expect(32'h84, NO_CF, 32'h0);
        // long back-pressure while memory stalls at random
        add_event(ACT_MISPRED, 32'hC0);
        add_event(ACT_STALL, 30);
        add_expect(32'hC0, NO_CF, 32'h0);
        add_expect(32'hC4, NO_CF, 32'h0);
        add_expect(32'hC8, JUMP, 32'h20);
        add_event(ACT_STALL, 20);
        add_expect(32'h20, NO_CF, 32'h0);
        add_expect(32'h24, NO_CF, 32'h0);
        add_expect(32'h28, NO_CF, 32'h0);
        add_expect(32'h2C, BRANCH, 32'h20);
        add_event(ACT_STALL, 25);
        add_expect(32'h20, NO_CF, 32'h0);
        add_expect(32'h24, NO_CF, 32'h0);
        add_expect(32'h28, NO_CF, 32'h0);
    endtask

    // ----------------------------------------------------------------------
    // compare tasks
    // ----------------------------------------------------------------------
    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t: %s expected %b, actual %b", $time, name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t: %s expected %h, actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_entry(input fetch_entry_t exp, input fetch_entry_t act);
        if (act.pc !== exp.pc) begin
            errors++;
            $display("** Error at %0t: fetch_pc_o expected %h, actual %h",
                     $time, exp.pc, act.pc);
        end
        if (act.instr !== exp.instr) begin
            errors++;
            $display("** Error at %0t: fetch_instr_o expected %h, actual %h",
                     $time, exp.instr, act.instr);
        end
        if (act.target !== exp.target) begin
            errors++;
            $display("** Error at %0t: fetch_target_o expected %h, actual %h",
                     $time, exp.target, act.target);
        end
    endtask

    task automatic check_cf(input cf_e exp, input cf_e act);
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t: fetch_cf_o expected %s, actual %s",
                     $time, exp.name(), act.name());
        end
    endtask

    // ----------------------------------------------------------------------
    // back-end side
    // ----------------------------------------------------------------------
    // called on a falling edge, ready held until the entry transfers
    task automatic take_entry(input fetch_entry_t exp);
        fetch_entry_t act;
        fetch_ready_i = 1'b1;
        while (!fetch_valid_o) begin
            @(negedge clk_i);
        end
        act = '{pc: fetch_pc_o, instr: fetch_instr_o, cf: fetch_cf_o,
                target: fetch_target_o};
        check_entry(exp, act);
        check_cf(exp.cf, act.cf);
        @(negedge clk_i);
        fetch_ready_i = 1'b0;
    endtask

    // one-cycle redirect or branch resolution
    task automatic drive_backend_event(input act_e act, input addr_t value);
        ex_valid_i       = (act == ACT_EXCEPT) || (act == ACT_EX_ERET);
        eret_i           = (act == ACT_ERET) || (act == ACT_EX_ERET);
        res_valid_i      = (act == ACT_TAKEN) || (act == ACT_NOT_TAKEN) || (act == ACT_MISPRED);
        res_is_branch_i  = (act == ACT_TAKEN) || (act == ACT_NOT_TAKEN);
        res_taken_i      = (act == ACT_TAKEN);
        res_mispredict_i = (act == ACT_MISPRED);
        res_pc_i         = value;
        res_target_i     = value;
        @(negedge clk_i);
        ex_valid_i       = 1'b0;
        eret_i           = 1'b0;
        res_valid_i      = 1'b0;
        res_is_branch_i  = 1'b0;
        res_taken_i      = 1'b0;
        res_mispredict_i = 1'b0;
    endtask

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------
    initial begin
        rst_ni           = 1'b0;
        boot_addr_i      = BOOT_ADDR;
        fetch_ready_i    = 1'b0;
        ex_valid_i       = 1'b0;
        trap_vector_i    = TRAP_VEC;
        eret_i           = 1'b0;
        epc_i            = EPC;
        res_valid_i      = 1'b0;
        res_pc_i         = '0;
        res_is_branch_i  = 1'b0;
        res_taken_i      = 1'b0;
        res_mispredict_i = 1'b0;
        res_target_i     = '0;
        build_program();
        build_table();
        table_ready = 1'b1;
        repeat (4) @(negedge clk_i);
        // memory stays idle while reset is held
        check_bit("imem_req_o", 1'b0, imem_req_o);
        rst_ni = 1'b1;
        check_bit("fetch_valid_o", 1'b0, fetch_valid_o);
        // first request goes to the boot address
        while (!imem_req_o) begin
            @(negedge clk_i);
        end
        check_addr("imem_addr_o", BOOT_ADDR, imem_addr_o);
        foreach (rows[i]) begin
            case (rows[i].act)
                ACT_EXPECT: take_entry(rows[i].exp);
                ACT_STALL:  repeat (rows[i].value) @(negedge clk_i);
                default:    drive_backend_event(rows[i].act, rows[i].value);
            endcase
        end
        $display("%0d errors in %0d table rows", errors, rows.size());
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // run limit scales with the table length
    initial begin
        int limit;
        wait (table_ready);
        limit = rows.size() * 40 + 200;
        repeat (limit) @(posedge clk_i);
        $display("timeout: table not finished after %0d cycles, run stopped", limit);
        $display("Checks failed");
        $finish;
    end

endmodule

/* sources.f */
source/riscv_isa_pkg.sv
source/frontend_pkg.sv
source/bp_resolve_if.sv
source/predict_if.sv
source/fetch_ctrl.sv
source/branch_predict.sv
source/bht.sv
source/instr_queue.sv
source/frontend_top.sv
verification/imem_model.sv
verification/frontend_tb.sv

/* Makefile */
# Verilator build for the fetch frontend

TOP := frontend_tb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f sources.f --top-module frontend_top

sim:
	verilator --binary --timing -f sources.f --top-module $(TOP) --Mdir obj_dir -o sim
	./obj_dir/sim | tee $(LOG)
	grep -q "^All checks passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
